/* common/umi_cmd_pkg.sv */
package umi_cmd_pkg;

   //####################################################################
   // Command word field positions
   //####################################################################

   localparam int CMD_OPCODE_LSB = 0;   // Opcode, bits 4:0
   localparam int CMD_OPCODE_W   = 5;
   localparam int CMD_SIZE_LSB   = 5;   // Item size as log2 bytes, bits 7:5
   localparam int CMD_SIZE_W     = 3;
   localparam int CMD_LEN_LSB    = 8;   // Items minus one, bits 15:8
   localparam int CMD_LEN_W      = 8;
   localparam int CMD_EOM_BIT    = 24;  // End of message

   // Largest item size that fits a 64-bit piece
   localparam int CMD_SIZE_MAX   = 3;

   //####################################################################
   // Opcodes
   //####################################################################

   typedef enum logic [CMD_OPCODE_W-1:0]
   {
      UMI_REQ_READ   = 5'd1,
      UMI_RESP_READ  = 5'd2,   // Carries data
      UMI_REQ_WRITE  = 5'd3,   // Carries data
      UMI_RESP_WRITE = 5'd4,
      UMI_REQ_POSTED = 5'd5    // Carries data
   } umi_opcode_e;

   //####################################################################
   // Split stage FSM
   //####################################################################

   typedef enum logic
   {
      SPLIT_IDLE,   // Waiting for a transaction
      SPLIT_BUSY    // Emitting pieces
   } split_state_e;

endpackage

/* common/umi_width_pkg.sv */
package umi_width_pkg;

   // Bus widths
   localparam int CW  = 32;    // Command
   localparam int AW  = 64;    // Address
   localparam int IDW = 256;   // Input data
   localparam int ODW = 64;    // Output data

   // Piece FIFO
   localparam int FIFO_DEPTH = 4;

   // One FIFO word holds cmd, dstaddr, srcaddr and data
   localparam int PIECE_W = CW + 2 * AW + ODW;

   // Bus word types
   typedef logic [CW-1:0]  umi_cmd_t;
   typedef logic [AW-1:0]  umi_addr_t;
   typedef logic [IDW-1:0] umi_idata_t;
   typedef logic [ODW-1:0] umi_odata_t;

endpackage

/* src/split/umi_split_stage.sv */
`timescale 1ns/1ps

module umi_split_stage
(
   input  logic                   umi_in_clk,
   input  logic                   umi_in_nreset,
   // Wide input side
   input  logic                   umi_in_valid,
   input  umi_width_pkg::umi_cmd_t   umi_in_cmd,
   input  umi_width_pkg::umi_addr_t  umi_in_dstaddr,
   input  umi_width_pkg::umi_addr_t  umi_in_srcaddr,
   input  umi_width_pkg::umi_idata_t umi_in_data,
   output logic                   umi_in_ready,
   // Narrow piece side
   output logic                   piece_valid,
   output umi_width_pkg::umi_cmd_t   piece_cmd,
   output umi_width_pkg::umi_addr_t  piece_dstaddr,
   output umi_width_pkg::umi_addr_t  piece_srcaddr,
   output umi_width_pkg::umi_odata_t piece_data,
   input  logic                   piece_ready
);

   import umi_width_pkg::*;
   import umi_cmd_pkg::*;

   split_state_e state;
   logic [8:0]   rem_q;          // Items still to send
   umi_cmd_t     cmd_q;
   umi_addr_t    dst_q;
   umi_addr_t    src_q;
   umi_idata_t   data_q;

   umi_opcode_e  opcode;
   logic         has_data;
   logic [8:0]   items_per_beat;
   logic [8:0]   piece_count;
   logic [7:0]   piece_len;
   logic         last_piece;
   logic         in_fire;
   logic         piece_fire;

   logic [2:0]   in_size;
   logic [7:0]   in_len;
   logic [11:0]  in_bytes;

   //####################################################################
   // Piece decode from held transaction
   //####################################################################

   assign opcode   = umi_opcode_e'(cmd_q[CMD_OPCODE_LSB +: CMD_OPCODE_W]);
   assign has_data = opcode inside {UMI_RESP_READ, UMI_REQ_WRITE, UMI_REQ_POSTED};

   assign items_per_beat = 9'd8 >> cmd_q[CMD_SIZE_LSB +: CMD_SIZE_W];
   assign piece_count    = (rem_q < items_per_beat) ? rem_q : items_per_beat;
   assign piece_len      = piece_count[7:0] - 8'd1;
   assign last_piece     = (rem_q <= items_per_beat);

   always_comb
   begin
      piece_cmd = cmd_q;
      piece_cmd[CMD_LEN_LSB +: CMD_LEN_W] = piece_len;
      piece_cmd[CMD_EOM_BIT] = cmd_q[CMD_EOM_BIT] & last_piece;   // EOM on last only
   end

   assign piece_dstaddr = dst_q;
   assign piece_srcaddr = src_q;
   assign piece_data    = has_data ? data_q[ODW-1:0] : '0;

   //####################################################################
   // Handshakes
   //####################################################################

   assign piece_valid  = (state == SPLIT_BUSY);
   assign piece_fire   = piece_valid & piece_ready;
   // Accept the next one as the last piece leaves
   assign umi_in_ready = (state == SPLIT_IDLE) | (piece_fire & last_piece);
   assign in_fire      = umi_in_valid & umi_in_ready;

   // FSM and item counter
   always_ff @(posedge umi_in_clk or negedge umi_in_nreset)
   begin
      if (!umi_in_nreset)
      begin
         state <= SPLIT_IDLE;
         rem_q <= '0;
      end
      else if (in_fire)
      begin
         state <= SPLIT_BUSY;
         rem_q <= {1'b0, umi_in_cmd[CMD_LEN_LSB +: CMD_LEN_W]} + 9'd1;
      end
      else if (piece_fire)
      begin
         if (last_piece)
            state <= SPLIT_IDLE;
         rem_q <= rem_q - piece_count;
      end
   end

   // Transaction hold, advanced per piece
   always_ff @(posedge umi_in_clk)
   begin
      if (in_fire)
      begin
         cmd_q  <= umi_in_cmd;
         dst_q  <= umi_in_dstaddr;
         src_q  <= umi_in_srcaddr;
         data_q <= umi_in_data;
      end
      else if (piece_fire)
      begin
         dst_q  <= dst_q + umi_addr_t'(ODW / 8);
         src_q  <= src_q + umi_addr_t'(ODW / 8);
         data_q <= data_q >> ODW;   // Next slice to the bottom
      end
   end

   //####################################################################
   // Checks
   //####################################################################

   assign in_size  = umi_in_cmd[CMD_SIZE_LSB +: CMD_SIZE_W];
   assign in_len   = umi_in_cmd[CMD_LEN_LSB +: CMD_LEN_W];
   assign in_bytes = ({4'd0, in_len} + 12'd1) << in_size;

   a_in_size : assert property (@(posedge umi_in_clk) disable iff (!umi_in_nreset)
      in_fire |-> (in_size <= 3'(CMD_SIZE_MAX)));

   // Whole transaction must fit the wide data bus
   a_in_bytes : assert property (@(posedge umi_in_clk) disable iff (!umi_in_nreset)
      in_fire |-> (in_bytes <= 12'(IDW / 8)));

   a_piece_hold : assert property (@(posedge umi_in_clk) disable iff (!umi_in_nreset)
      (piece_valid && !piece_ready) |=> (piece_valid && $stable(piece_cmd)
                                         && $stable(piece_dstaddr)
                                         && $stable(piece_srcaddr)
                                         && $stable(piece_data)));

endmodule

/* src/fifo/umi_sync_fifo.sv */
`timescale 1ns/1ps

module umi_sync_fifo
#(
   parameter int DEPTH = umi_width_pkg::FIFO_DEPTH,
   parameter int DW    = umi_width_pkg::PIECE_W
)
(
   input  logic          umi_in_clk,
   input  logic          umi_in_nreset,
   input  logic          chaosmode,    // Random pushback on the write side
   // Write side
   input  logic          wr_valid,
   input  logic [DW-1:0] wr_din,
   output logic          wr_ready,
   // Read side
   output logic          rd_valid,
   output logic [DW-1:0] rd_dout,
   input  logic          rd_ready,
   // Status
   output logic          fifo_full,
   output logic          fifo_empty
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

   logic [DW-1:0]    mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [PTR_W:0]   count;
   logic [15:0]      lfsr;
   logic             chaos_stall;
   logic             wr_fire;
   logic             rd_fire;

   assign fifo_full  = (count == (PTR_W+1)'(DEPTH));
   assign fifo_empty = (count == '0);

   // ##################################################################
   // Chaos pushback
   // ##################################################################

   always_ff @(posedge umi_in_clk or negedge umi_in_nreset)
   begin
      if (!umi_in_nreset)
         lfsr <= 16'h0001;
      else
         lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
   end

   assign chaos_stall = chaosmode & lfsr[0] & lfsr[3];   // Roughly one cycle in four

   assign wr_ready = ~fifo_full & ~chaos_stall;
   assign rd_valid = ~fifo_empty;
   assign wr_fire  = wr_valid & wr_ready;
   assign rd_fire  = rd_valid & rd_ready;

   // Pointers and occupancy
   always_ff @(posedge umi_in_clk or negedge umi_in_nreset)
   begin
      if (!umi_in_nreset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (wr_fire)
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (rd_fire)
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         count <= count + (PTR_W+1)'(wr_fire) - (PTR_W+1)'(rd_fire);
      end
   end

   always_ff @(posedge umi_in_clk)
   begin
      if (wr_fire)
         mem[wr_ptr] <= wr_din;
   end

   assign rd_dout = mem[rd_ptr];

   // Full and not drained, so no write may land
   a_no_write_full : assert property (@(posedge umi_in_clk) disable iff (!umi_in_nreset)
      (fifo_full && !rd_fire) |=> (fifo_full && $stable(wr_ptr)));

   a_no_read_empty : assert property (@(posedge umi_in_clk) disable iff (!umi_in_nreset)
      (fifo_empty && !wr_fire) |=> (fifo_empty && $stable(rd_ptr)));

endmodule

/* src/umi_fifo_width.sv */
`timescale 1ns/1ps

module umi_fifo_width
(
   input  logic                   umi_in_clk,
   input  logic                   umi_in_nreset,
   input  logic                   chaosmode,
   // Wide input
   input  logic                   umi_in_valid,
   input  umi_width_pkg::umi_cmd_t   umi_in_cmd,
   input  umi_width_pkg::umi_addr_t  umi_in_dstaddr,
   input  umi_width_pkg::umi_addr_t  umi_in_srcaddr,
   input  umi_width_pkg::umi_idata_t umi_in_data,
   output logic                   umi_in_ready,
   // Narrow output
   output logic                   umi_out_valid,
   output umi_width_pkg::umi_cmd_t   umi_out_cmd,
   output umi_width_pkg::umi_addr_t  umi_out_dstaddr,
   output umi_width_pkg::umi_addr_t  umi_out_srcaddr,
   output umi_width_pkg::umi_odata_t umi_out_data,
   input  logic                   umi_out_ready,
   // Status
   output logic                   fifo_full,
   output logic                   fifo_empty
);

   import umi_width_pkg::*;

   logic               piece_valid;
   umi_cmd_t           piece_cmd;
   umi_addr_t          piece_dstaddr;
   umi_addr_t          piece_srcaddr;
   umi_odata_t         piece_data;
   logic               piece_ready;
   logic [PIECE_W-1:0] fifo_din;
   logic [PIECE_W-1:0] fifo_dout;

   umi_split_stage u_split
   (
      .umi_in_clk     (umi_in_clk),
      .umi_in_nreset  (umi_in_nreset),
      .umi_in_valid   (umi_in_valid),
      .umi_in_cmd     (umi_in_cmd),
      .umi_in_dstaddr (umi_in_dstaddr),
      .umi_in_srcaddr (umi_in_srcaddr),
      .umi_in_data    (umi_in_data),
      .umi_in_ready   (umi_in_ready),
      .piece_valid    (piece_valid),
      .piece_cmd      (piece_cmd),
      .piece_dstaddr  (piece_dstaddr),
      .piece_srcaddr  (piece_srcaddr),
      .piece_data     (piece_data),
      .piece_ready    (piece_ready)
   );

   // Word layout, cmd in the low bits
   assign fifo_din = {piece_data, piece_srcaddr, piece_dstaddr, piece_cmd};

   umi_sync_fifo #(.DEPTH(FIFO_DEPTH), .DW(PIECE_W)) u_fifo
   (
      .umi_in_clk    (umi_in_clk),
      .umi_in_nreset (umi_in_nreset),
      .chaosmode     (chaosmode),
      .wr_valid      (piece_valid),
      .wr_din        (fifo_din),
      .wr_ready      (piece_ready),
      .rd_valid      (umi_out_valid),
      .rd_dout       (fifo_dout),
      .rd_ready      (umi_out_ready),
      .fifo_full     (fifo_full),
      .fifo_empty    (fifo_empty)
   );

   assign umi_out_cmd     = fifo_dout[0 +: CW];
   assign umi_out_dstaddr = fifo_dout[CW +: AW];
   assign umi_out_srcaddr = fifo_dout[CW+AW +: AW];
   assign umi_out_data    = fifo_dout[CW+2*AW +: ODW];

endmodule

/* dv/tb_umi_fifo_width.sv */
`timescale 1ns/1ps

module tb_umi_fifo_width;

   import umi_width_pkg::*;
   import umi_cmd_pkg::*;

   localparam int NROWS      = 11;
   localparam int TIMEOUT    = 2000;   // Cycles per wait loop
   localparam int OUT_READY  = 0;
   localparam int OUT_RANDOM = 1;
   localparam int OUT_HOLD   = 2;

   logic       umi_in_clk;
   logic       umi_in_nreset;
   logic       chaosmode;
   logic       umi_in_valid;
   umi_cmd_t   umi_in_cmd;
   umi_addr_t  umi_in_dstaddr;
   umi_addr_t  umi_in_srcaddr;
   umi_idata_t umi_in_data;
   logic       umi_in_ready;
   logic       umi_out_valid;
   umi_cmd_t   umi_out_cmd;
   umi_addr_t  umi_out_dstaddr;
   umi_addr_t  umi_out_srcaddr;
   umi_odata_t umi_out_data;
   logic       umi_out_ready;
   logic       fifo_full;
   logic       fifo_empty;

   // Stimulus table, one entry per input transaction
   string       row_name  [NROWS];
   umi_opcode_e row_op    [NROWS];
   int          row_size  [NROWS];
   int          row_len   [NROWS];
   logic        row_eom   [NROWS];
   umi_addr_t   row_dst   [NROWS];
   umi_addr_t   row_src   [NROWS];
   umi_idata_t  row_data  [NROWS];
   umi_cmd_t    row_cmd   [NROWS];
   int          row_mode  [NROWS];
   logic        row_chaos [NROWS];
   int          nrows;

   // Expected pieces in output order
   umi_cmd_t   exp_cmd  [$];
   umi_addr_t  exp_dst  [$];
   umi_addr_t  exp_src  [$];
   umi_odata_t exp_data [$];
   string      exp_name [$];

   logic [31:0] lcg_state;
   int          out_mode;

   umi_fifo_width u_umi_fifo_width
   (
      .umi_in_clk      (umi_in_clk),
      .umi_in_nreset   (umi_in_nreset),
      .chaosmode       (chaosmode),
      .umi_in_valid    (umi_in_valid),
      .umi_in_cmd      (umi_in_cmd),
      .umi_in_dstaddr  (umi_in_dstaddr),
      .umi_in_srcaddr  (umi_in_srcaddr),
      .umi_in_data     (umi_in_data),
      .umi_in_ready    (umi_in_ready),
      .umi_out_valid   (umi_out_valid),
      .umi_out_cmd     (umi_out_cmd),
      .umi_out_dstaddr (umi_out_dstaddr),
      .umi_out_srcaddr (umi_out_srcaddr),
      .umi_out_data    (umi_out_data),
      .umi_out_ready   (umi_out_ready),
      .fifo_full       (fifo_full),
      .fifo_empty      (fifo_empty)
   );

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic logic carries_data(input umi_opcode_e op);
      return (op == UMI_RESP_READ) || (op == UMI_REQ_WRITE) || (op == UMI_REQ_POSTED);
   endfunction

   //####################################################################
   // Failure reporting and compare tasks
   //####################################################################

   task automatic report_failure();
      $display("Test FAILED");
      $fatal(1, "stopping at first error");
   endtask

   task automatic timeout_fail(input string what);
      $display("Timeout after %0d cycles waiting for %s", TIMEOUT, what);
      report_failure();
   endtask

   task automatic check_cmd(input string name, input umi_cmd_t exp, input umi_cmd_t act);
      if (exp !== act)
      begin
         $display("MISMATCH %s cmd expected %h actual %h", name, exp, act);
         report_failure();
      end
   endtask

   task automatic check_addr(input string name, input string field, input umi_addr_t exp,
                             input umi_addr_t act);
      if (exp !== act)
      begin
         $display("MISMATCH %s %s expected %h actual %h", name, field, exp, act);
         report_failure();
      end
   endtask

   task automatic check_data(input string name, input umi_odata_t exp, input umi_odata_t act);
      if (exp !== act)
      begin
         $display("MISMATCH %s data expected %h actual %h", name, exp, act);
         report_failure();
      end
   endtask

   task automatic check_flag(input string name, input string field, input logic exp,
                             input logic act);
      if (exp !== act)
      begin
         $display("MISMATCH %s %s expected %0b actual %0b", name, field, exp, act);
         report_failure();
      end
   endtask

   //####################################################################
   // Table, reference model, driver
   //####################################################################

   task automatic add_row(input string name, input umi_opcode_e op, input int size,
                          input int len, input logic eom, input umi_addr_t dst,
                          input umi_addr_t src, input int mode, input logic chaos);
      umi_cmd_t cmd;
      cmd = '0;
      cmd[CMD_OPCODE_LSB +: CMD_OPCODE_W] = op;
      cmd[CMD_SIZE_LSB +: CMD_SIZE_W]     = 3'(size);
      cmd[CMD_LEN_LSB +: CMD_LEN_W]       = 8'(len);
      cmd[23:16]                          = 8'(nrows * 29 + 5);   // Spare bits
      cmd[CMD_EOM_BIT]                    = eom;
      cmd[31:25]                          = 7'h35;
      row_name[nrows]  = name;
      row_op[nrows]    = op;
      row_size[nrows]  = size;
      row_len[nrows]   = len;
      row_eom[nrows]   = eom;
      row_dst[nrows]   = dst;
      row_src[nrows]   = src;
      row_cmd[nrows]   = cmd;
      row_mode[nrows]  = mode;
      row_chaos[nrows] = chaos;
      for (int j = 0; j < IDW / 32; j++)
      begin
         lcg_state = lcg_next(lcg_state);
         row_data[nrows][32*j +: 32] = lcg_state;
      end
      nrows++;
   endtask

   // Expected pieces straight from the split rule
   task automatic model_split(input int idx);
      umi_cmd_t pc;
      int       ipb;
      int       rem;
      int       cnt;
      int       k;
      ipb = 8 >> row_size[idx];
      rem = row_len[idx] + 1;
      k   = 0;
      while (rem > 0)
      begin
         cnt = (rem < ipb) ? rem : ipb;
         pc  = row_cmd[idx];
         pc[CMD_LEN_LSB +: CMD_LEN_W] = 8'(cnt - 1);
         pc[CMD_EOM_BIT] = (rem == cnt) ? row_eom[idx] : 1'b0;
         exp_cmd.push_back(pc);
         exp_dst.push_back(row_dst[idx] + umi_addr_t'(8 * k));
         exp_src.push_back(row_src[idx] + umi_addr_t'(8 * k));
         if (carries_data(row_op[idx]))
            exp_data.push_back(row_data[idx][64*k +: 64]);
         else
            exp_data.push_back('0);
         exp_name.push_back(row_name[idx]);
         rem -= cnt;
         k++;
      end
   endtask

   // Called 1 ns after a rising edge, returns at the same phase
   task automatic send_row(input int idx);
      int cycles;
      umi_in_valid   = 1'b1;
      umi_in_cmd     = row_cmd[idx];
      umi_in_dstaddr = row_dst[idx];
      umi_in_srcaddr = row_src[idx];
      umi_in_data    = row_data[idx];
      cycles = 0;
      @(negedge umi_in_clk);
      while (!umi_in_ready)
      begin
         cycles++;
         if (cycles > TIMEOUT)
            timeout_fail({"umi_in_ready on ", row_name[idx]});
         @(negedge umi_in_clk);
      end
      model_split(idx);   // Accepted at the coming edge
      @(posedge umi_in_clk);
      #1;
      umi_in_valid = 1'b0;
   endtask

   task automatic wait_drain();
      int cycles;
      cycles = 0;
      while (exp_cmd.size() != 0)
      begin
         cycles++;
         if (cycles > TIMEOUT)
            timeout_fail("all expected pieces to reach the output");
         @(posedge umi_in_clk);
         #1;
      end
   endtask

   // Output stalled: FIFO fills, then the input side stops
   task automatic check_backpressure(input string name);
      int cycles;
      cycles = 0;
      while (!fifo_full)
      begin
         cycles++;
         if (cycles > TIMEOUT)
            timeout_fail("fifo_full with the output stalled");
         @(posedge umi_in_clk);
         #1;
      end
      check_flag(name, "umi_in_ready", 1'b0, umi_in_ready);
      out_mode = OUT_READY;
   endtask

   task automatic build_table();
      add_row("wr_s3_l0", UMI_REQ_WRITE, 3, 0, 1'b1, 64'h0000_0001_0000_0100,
              64'h0000_0002_0000_0200, OUT_READY, 1'b0);
      add_row("wr_s0_l7", UMI_REQ_WRITE, 0, 7, 1'b1, 64'h0000_0001_0000_0180,
              64'h0000_0002_0000_0280, OUT_READY, 1'b0);
      add_row("wr_s0_l31", UMI_REQ_WRITE, 0, 31, 1'b1, 64'h0000_0000_ffff_fff0,
              64'h8000_0000_0000_1000, OUT_READY, 1'b0);
      add_row("rd_s2_l7", UMI_REQ_READ, 2, 7, 1'b1, 64'h0000_0003_0000_0040,
              64'h0000_0004_0000_0080, OUT_READY, 1'b0);
      add_row("mix_req_read", UMI_REQ_READ, 3, 1, 1'b0, 64'h0000_0000_0000_2000,
              64'h0000_0000_0000_3000, OUT_READY, 1'b0);
      add_row("mix_resp_read", UMI_RESP_READ, 2, 3, 1'b1, 64'h0000_0000_0000_3000,
              64'h0000_0000_0000_2000, OUT_READY, 1'b0);
      add_row("mix_req_write", UMI_REQ_WRITE, 1, 15, 1'b1, 64'h1234_5678_0000_0010,
              64'h0000_0000_0000_4000, OUT_READY, 1'b0);
      add_row("mix_resp_write", UMI_RESP_WRITE, 3, 3, 1'b0, 64'h0000_0000_0000_4000,
              64'h1234_5678_0000_0010, OUT_READY, 1'b0);
      add_row("mix_posted", UMI_REQ_POSTED, 0, 20, 1'b1, 64'h0000_00ff_ffff_ffe8,
              64'h0000_0000_0000_5000, OUT_READY, 1'b1);
      add_row("bp_fill", UMI_REQ_WRITE, 0, 31, 1'b1, 64'h0000_0000_0000_6000,
              64'h0000_0000_0000_7000, OUT_HOLD, 1'b0);
      add_row("bp_stall", UMI_REQ_POSTED, 3, 2, 1'b1, 64'h0000_0000_0000_8000,
              64'h0000_0000_0000_9000, OUT_HOLD, 1'b0);
   endtask

   //####################################################################
   // Clock, output ready, monitor
   //####################################################################

   initial
   begin
      umi_in_clk = 1'b0;
      forever #5 umi_in_clk = ~umi_in_clk;
   end

   // Mode sampled at the edge, ready driven 1 ns later
   initial
   begin : ready_driver
      int mode_now;
      forever
      begin
         @(posedge umi_in_clk);
         mode_now  = out_mode;
         lcg_state = lcg_next(lcg_state);
         #1;
         if (mode_now == OUT_HOLD)
            umi_out_ready = 1'b0;
         else if (mode_now == OUT_RANDOM)
            umi_out_ready = (lcg_state[17:16] != 2'b00);   // About 3 in 4
         else
            umi_out_ready = 1'b1;
      end
   end

   initial
   begin : monitor
      string name;
      forever
      begin
         @(negedge umi_in_clk);
         if (umi_in_nreset && umi_out_valid === 1'b1 && umi_out_ready === 1'b1)
         begin
            if (exp_cmd.size() == 0)
            begin
               $display("Output piece with cmd %h arrived with no piece expected", umi_out_cmd);
               report_failure();
            end
            name = exp_name.pop_front();
            check_cmd(name, exp_cmd.pop_front(), umi_out_cmd);
            check_addr(name, "dstaddr", exp_dst.pop_front(), umi_out_dstaddr);
            check_addr(name, "srcaddr", exp_src.pop_front(), umi_out_srcaddr);
            check_data(name, exp_data.pop_front(), umi_out_data);
         end
      end
   end

   //####################################################################
   // Main sequence
   //####################################################################

   initial
   begin
      int cur_mode;
      nrows          = 0;
      lcg_state      = 32'h7e5d_5e88;
      out_mode       = OUT_READY;
      umi_in_nreset  = 1'b0;
      chaosmode      = 1'b0;
      umi_in_valid   = 1'b0;
      umi_in_cmd     = '0;
      umi_in_dstaddr = '0;
      umi_in_srcaddr = '0;
      umi_in_data    = '0;
      umi_out_ready  = 1'b0;
      build_table();
      repeat (16) @(posedge umi_in_clk);
      #1;
      umi_in_nreset = 1'b1;
      @(posedge umi_in_clk);
      #1;
      check_flag("reset", "umi_in_ready", 1'b1, umi_in_ready);
      check_flag("reset", "umi_out_valid", 1'b0, umi_out_valid);
      check_flag("reset", "fifo_empty", 1'b1, fifo_empty);
      check_flag("reset", "fifo_full", 1'b0, fifo_full);

      // Directed pass, each row with its own output mode
      cur_mode = OUT_READY;
      for (int i = 0; i < nrows; i++)
      begin
         if (row_mode[i] != cur_mode)
         begin
            if (cur_mode == OUT_HOLD)
               check_backpressure(row_name[i-1]);
            else
               wait_drain();
            cur_mode = row_mode[i];
         end
         out_mode  = cur_mode;
         chaosmode = row_chaos[i];
         send_row(i);
      end
      if (cur_mode == OUT_HOLD)
         check_backpressure(row_name[nrows-1]);
      out_mode = OUT_READY;
      wait_drain();

      // Whole table again under random stalls and chaos
      out_mode  = OUT_RANDOM;
      chaosmode = 1'b1;
      for (int i = 0; i < nrows; i++)
         send_row(i);
      wait_drain();
      chaosmode = 1'b0;
      out_mode  = OUT_READY;

      repeat (4) @(posedge umi_in_clk);
      #1;
      check_flag("final", "fifo_empty", 1'b1, fifo_empty);
      check_flag("final", "umi_out_valid", 1'b0, umi_out_valid);
      check_flag("final", "umi_in_ready", 1'b1, umi_in_ready);

      $display("Test OK");
      $finish;
   end

endmodule

/* umi_fifo_width.f */
common/umi_cmd_pkg.sv
common/umi_width_pkg.sv
src/split/umi_split_stage.sv
src/fifo/umi_sync_fifo.sv
src/umi_fifo_width.sv
dv/tb_umi_fifo_width.sv

/* Bender.yml */
package:
  name: umi_fifo_width

sources:
  # Shared packages
  - common/umi_cmd_pkg.sv
  - common/umi_width_pkg.sv
  # Design
  - src/split/umi_split_stage.sv
  - src/fifo/umi_sync_fifo.sv
  - src/umi_fifo_width.sv
  # Testbench
  - target: test
    files:
      - dv/tb_umi_fifo_width.sv
